//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN = 32;  // data and pc width

  // trap bus layout
  localparam int TRAP_LEN          = 8;
  localparam int TRAP_AMO_MISALIGN = 6;  // bit index

  // instruction class from the decoder
  typedef enum logic [3:0] {
    EXC_NONE,
    EXC_LUI,
    EXC_AUIPC,
    EXC_JAL,
    EXC_JALR,
    EXC_BRANCH,
    EXC_LOAD,
    EXC_STORE,
    EXC_OPIMM,
    EXC_OPREG,
    EXC_CSR,
    EXC_AMO
  } exc_op_e;

  // alu function, the last six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_RW,
    CSR_RS,
    CSR_RC
  } csr_op_e;

  typedef enum logic [3:0] {
    AMO_NONE,
    AMO_LR,
    AMO_SC,
    AMO_SWAP,
    AMO_ADD,
    AMO_XOR,
    AMO_AND,
    AMO_OR,
    AMO_MIN,
    AMO_MAX,
    AMO_MINU,
    AMO_MAXU
  } amo_op_e;

endpackage

//--- hw/exu_pipe_pkg.sv
package exu_pipe_pkg;

  localparam int EX_CREDITS = 2;  // result slots in the memory stage

  // decoded instruction entering execute
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    logic [4:0]                      rd;
    logic [rv_isa_pkg::XLEN-1:0]     rs1;       // register values, not indices
    logic [rv_isa_pkg::XLEN-1:0]     rs2;
    logic [rv_isa_pkg::XLEN-1:0]     imm;
    logic [11:0]                     csr_addr;
    logic [rv_isa_pkg::XLEN-1:0]     csr_data;  // csr read value
    logic [4:0]                      csr_imm;
    logic                            csr_imm_valid;
    rv_isa_pkg::exc_op_e             exc_op;
    rv_isa_pkg::alu_op_e             alu_op;
    rv_isa_pkg::csr_op_e             csr_op;
    rv_isa_pkg::amo_op_e             amo_op;
    logic                            pdt_res;   // predicted taken
    logic                            pdt_which;
    logic [7:0]                      history;
    logic [rv_isa_pkg::TRAP_LEN-1:0] trap;
  } ex_req_t;

  // result handed to the memory stage
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    logic [4:0]                      rd;
    logic [rv_isa_pkg::XLEN-1:0]     alu_data;
    logic                            csr_valid;
    logic [11:0]                     csr_addr;
    logic [rv_isa_pkg::XLEN-1:0]     csr_data;  // new csr value
    rv_isa_pkg::amo_op_e             amo_op;
    logic [rv_isa_pkg::XLEN-1:0]     amo_rs2;
    logic [rv_isa_pkg::TRAP_LEN-1:0] trap;
    rv_isa_pkg::exc_op_e             exc_op;
  } ex_res_t;

  typedef struct packed {
    logic                        valid;
    logic [rv_isa_pkg::XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic                        valid;
    logic                        taken;
    logic                        correct;
    logic [1:0]                  jump_type;  // 1 jal, 2 jalr, 3 branch
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic                        pdt_which;
    logic [7:0]                  history;
  } bpu_upd_t;

endpackage

//--- hw/alu.sv
`timescale 1ns/100ps

module alu (
  input  logic [rv_isa_pkg::XLEN-1:0] a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] b_i,
  input  rv_isa_pkg::alu_op_e         op_i,
  output logic [rv_isa_pkg::XLEN-1:0] result_o,
  output logic                        cmp_o
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (op_i)
      rv_isa_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv_isa_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv_isa_pkg::ALU_SLL:  result_o = a_i << shamt;
      rv_isa_pkg::ALU_SLT:  result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_s};
      rv_isa_pkg::ALU_SLTU: result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_u};
      rv_isa_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv_isa_pkg::ALU_SRL:  result_o = a_i >> shamt;
      rv_isa_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;  // sign fill
      rv_isa_pkg::ALU_OR:   result_o = a_i | b_i;
      rv_isa_pkg::ALU_AND:  result_o = a_i & b_i;
      // branch compares only drive cmp_o
      rv_isa_pkg::ALU_BEQ:  cmp_o = eq;
      rv_isa_pkg::ALU_BNE:  cmp_o = ~eq;
      rv_isa_pkg::ALU_BLT:  cmp_o = lt_s;
      rv_isa_pkg::ALU_BGE:  cmp_o = ~lt_s;
      rv_isa_pkg::ALU_BLTU: cmp_o = lt_u;
      rv_isa_pkg::ALU_BGEU: cmp_o = ~lt_u;
      default: begin
        result_o = '0;
        cmp_o    = 1'b0;
      end
    endcase
  end

endmodule

//--- hw/branch_unit.sv
`timescale 1ns/100ps

module branch_unit (
  input  exu_pipe_pkg::ex_req_t   req_i,
  input  logic                    cmp_i,
  output exu_pipe_pkg::redirect_t redirect_o,
  output exu_pipe_pkg::bpu_upd_t  bpu_upd_o
);

  logic                        is_jal;
  logic                        is_jalr;
  logic                        is_branch;
  logic                        taken;
  logic [rv_isa_pkg::XLEN-1:0] tgt_base;
  logic [rv_isa_pkg::XLEN-1:0] tgt_off;

  assign is_jal    = (req_i.exc_op == rv_isa_pkg::EXC_JAL);
  assign is_jalr   = (req_i.exc_op == rv_isa_pkg::EXC_JALR);
  assign is_branch = (req_i.exc_op == rv_isa_pkg::EXC_BRANCH);

  assign taken = is_jal | is_jalr | (is_branch & cmp_i);

  // predicted taken but fell through, go back to pc+4
  always_comb begin
    if (req_i.pdt_res && !taken) begin
      tgt_base = req_i.pc;
      tgt_off  = rv_isa_pkg::XLEN'(4);
    end else begin
      tgt_base = is_jalr ? req_i.rs1 : req_i.pc;
      tgt_off  = req_i.imm;
    end
  end

  assign redirect_o.valid = (taken != req_i.pdt_res) &
                            (req_i.exc_op != rv_isa_pkg::EXC_AMO);
  assign redirect_o.pc    = tgt_base + tgt_off;

  assign bpu_upd_o.valid     = is_jal | is_jalr | is_branch;
  assign bpu_upd_o.taken     = taken;
  assign bpu_upd_o.correct   = (taken == req_i.pdt_res);
  assign bpu_upd_o.jump_type = is_jal    ? 2'd1 :
                               is_jalr   ? 2'd2 :
                               is_branch ? 2'd3 : 2'd0;
  assign bpu_upd_o.pc        = req_i.pc;
  assign bpu_upd_o.pdt_which = req_i.pdt_which;
  assign bpu_upd_o.history   = req_i.history;

endmodule

//--- hw/exu.sv
`timescale 1ns/100ps

module exu (
  input  exu_pipe_pkg::ex_req_t   req_i,
  output exu_pipe_pkg::ex_res_t   res_o,
  output exu_pipe_pkg::redirect_t redirect_o,
  output exu_pipe_pkg::bpu_upd_t  bpu_upd_o,
  output logic                    amo_misalign_o
);

  logic [rv_isa_pkg::XLEN-1:0]     op_a;
  logic [rv_isa_pkg::XLEN-1:0]     op_b;
  logic [rv_isa_pkg::XLEN-1:0]     upper_imm;
  logic [rv_isa_pkg::XLEN-1:0]     alu_result;
  logic                            alu_cmp;
  logic [rv_isa_pkg::XLEN-1:0]     csr_src;
  logic [rv_isa_pkg::XLEN-1:0]     csr_new;
  logic                            is_amo;
  logic [rv_isa_pkg::TRAP_LEN-1:0] trap;

  assign upper_imm = {req_i.imm[rv_isa_pkg::XLEN-1:12], 12'b0};

  // operand select by instruction class
  always_comb begin
    op_a = '0;
    op_b = '0;
    case (req_i.exc_op)
      rv_isa_pkg::EXC_OPREG,
      rv_isa_pkg::EXC_BRANCH,
      rv_isa_pkg::EXC_AMO: begin
        op_a = req_i.rs1;
        op_b = req_i.rs2;
      end
      rv_isa_pkg::EXC_OPIMM,
      rv_isa_pkg::EXC_LOAD,
      rv_isa_pkg::EXC_STORE: begin
        op_a = req_i.rs1;
        op_b = req_i.imm;  // also the load/store address
      end
      rv_isa_pkg::EXC_JAL,
      rv_isa_pkg::EXC_JALR: begin
        op_a = req_i.pc;
        op_b = rv_isa_pkg::XLEN'(4);  // link address
      end
      rv_isa_pkg::EXC_AUIPC: begin
        op_a = req_i.pc;
        op_b = upper_imm;
      end
      rv_isa_pkg::EXC_LUI: op_b = upper_imm;
      rv_isa_pkg::EXC_CSR: op_b = req_i.csr_data;  // old csr value to rd
      default: begin
        op_a = '0;
        op_b = '0;
      end
    endcase
  end

  alu u_alu (
    .a_i     (op_a),
    .b_i     (op_b),
    .op_i    (req_i.alu_op),
    .result_o(alu_result),
    .cmp_o   (alu_cmp)
  );

  branch_unit u_branch_unit (
    .req_i     (req_i),
    .cmp_i     (alu_cmp),
    .redirect_o(redirect_o),
    .bpu_upd_o (bpu_upd_o)
  );

  // csr write data
  assign csr_src = req_i.csr_imm_valid ?
                   {{(rv_isa_pkg::XLEN-5){1'b0}}, req_i.csr_imm} : req_i.rs1;

  always_comb begin
    case (req_i.csr_op)
      rv_isa_pkg::CSR_RW: csr_new = csr_src;
      rv_isa_pkg::CSR_RS: csr_new = req_i.csr_data | csr_src;
      rv_isa_pkg::CSR_RC: csr_new = req_i.csr_data & ~csr_src;
      default:            csr_new = req_i.csr_data;
    endcase
  end

  // amo needs a word aligned address
  assign is_amo         = (req_i.exc_op == rv_isa_pkg::EXC_AMO);
  assign amo_misalign_o = is_amo & (req_i.rs1[1:0] != 2'b00);

  always_comb begin
    trap = req_i.trap;
    trap[rv_isa_pkg::TRAP_AMO_MISALIGN] = req_i.trap[rv_isa_pkg::TRAP_AMO_MISALIGN] |
                                          amo_misalign_o;
  end

  assign res_o.pc        = req_i.pc;
  assign res_o.rd        = req_i.rd;
  assign res_o.alu_data  = alu_result;
  assign res_o.csr_valid = (req_i.exc_op == rv_isa_pkg::EXC_CSR) &
                           (req_i.csr_op != rv_isa_pkg::CSR_NONE);
  assign res_o.csr_addr  = req_i.csr_addr;
  assign res_o.csr_data  = csr_new;
  assign res_o.amo_op    = is_amo ? req_i.amo_op : rv_isa_pkg::AMO_NONE;
  assign res_o.amo_rs2   = req_i.rs2;  // store operand for the amo
  assign res_o.trap      = trap;
  assign res_o.exc_op    = req_i.exc_op;

endmodule

//--- hw/ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        issue_valid_i,
  input  exu_pipe_pkg::ex_res_t       res_d_i,
  input  exu_pipe_pkg::redirect_t     redirect_d_i,
  input  exu_pipe_pkg::bpu_upd_t      bpu_d_i,
  input  logic                        amo_misalign_i,
  input  logic                        credit_i,
  input  logic                        amo_done_i,
  input  logic [rv_isa_pkg::XLEN-1:0] amo_result_i,
  output logic                        ex_stall_o,
  output logic                        res_valid_o,
  output exu_pipe_pkg::ex_res_t       res_o,
  output exu_pipe_pkg::redirect_t     redirect_o,
  output exu_pipe_pkg::bpu_upd_t      bpu_upd_o,
  output logic                        amo_req_o
);

  typedef enum logic [1:0] {
    IDLE,
    AMO_WAIT,
    AMO_SEND
  } state_e;

  typedef logic [$clog2(exu_pipe_pkg::EX_CREDITS+1)-1:0] credit_t;

  state_e state_q, state_d;

  credit_t credit_q, credit_d;
  credit_t credit_used;

  logic                        res_valid_q;
  logic                        redirect_valid_q;
  logic                        bpu_valid_q;
  exu_pipe_pkg::ex_res_t       res_q;
  exu_pipe_pkg::bpu_upd_t      bpu_q;
  logic [rv_isa_pkg::XLEN-1:0] redirect_pc_q;
  logic                        accept;
  logic                        is_amo;
  logic                        amo_finish;

  // a result on the output still holds its credit until the next edge
  always_comb begin
    credit_used    = '0;
    credit_used[0] = res_valid_q;
  end

  assign ex_stall_o = (credit_q <= credit_used) | (state_q != IDLE);
  assign accept     = issue_valid_i & ~ex_stall_o;
  assign is_amo     = (res_d_i.exc_op == rv_isa_pkg::EXC_AMO) & ~amo_misalign_i;
  assign amo_finish = (state_q == AMO_WAIT) & amo_done_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (accept && is_amo) state_d = AMO_WAIT;
      AMO_WAIT: if (amo_done_i) state_d = AMO_SEND;
      AMO_SEND: state_d = IDLE;  // result is on the output now
      default:  state_d = IDLE;
    endcase
  end

  always_comb begin
    credit_d = credit_q;
    if (res_valid_q && !credit_i) begin
      credit_d = credit_q - credit_t'(1);
    end else if (!res_valid_q && credit_i) begin
      credit_d = credit_q + credit_t'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q          <= IDLE;
      credit_q         <= credit_t'(exu_pipe_pkg::EX_CREDITS);
      res_valid_q      <= 1'b0;
      redirect_valid_q <= 1'b0;
      bpu_valid_q      <= 1'b0;
    end else begin
      state_q          <= state_d;
      credit_q         <= credit_d;
      res_valid_q      <= (accept & ~is_amo) | amo_finish;
      redirect_valid_q <= accept & ~is_amo & redirect_d_i.valid;
      bpu_valid_q      <= accept & ~is_amo & bpu_d_i.valid;
    end
  end

  // payload, held through the amo wait
  always_ff @(posedge clk) begin
    if (accept) begin
      res_q         <= res_d_i;
      redirect_pc_q <= redirect_d_i.pc;
      bpu_q         <= bpu_d_i;
    end else if (amo_finish) begin
      res_q.alu_data <= amo_result_i;  // rd gets the old memory word
    end
  end

  assign amo_req_o   = (state_q == AMO_WAIT);
  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  assign redirect_o.valid = redirect_valid_q;
  assign redirect_o.pc    = redirect_pc_q;

  always_comb begin
    bpu_upd_o       = bpu_q;
    bpu_upd_o.valid = bpu_valid_q;
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credit_q <= credit_t'(exu_pipe_pkg::EX_CREDITS));

  // memory stage must not return more slots than it owns
  a_credit_ovf: assert property (@(posedge clk) disable iff (rst)
    credit_i |-> (credit_q < credit_t'(exu_pipe_pkg::EX_CREDITS)) || res_valid_q);

  a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
    amo_done_i |-> state_q == AMO_WAIT);

  a_valid_credit: assert property (@(posedge clk) disable iff (rst)
    res_valid_o |-> credit_q != '0);

endmodule

//--- hw/exu_stage.sv
`timescale 1ns/100ps

module exu_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        issue_valid_i,
  input  exu_pipe_pkg::ex_req_t       issue_i,
  output logic                        ex_stall_o,
  output logic                        res_valid_o,
  output exu_pipe_pkg::ex_res_t       res_o,
  output exu_pipe_pkg::redirect_t     redirect_o,
  output exu_pipe_pkg::bpu_upd_t      bpu_upd_o,
  input  logic                        credit_i,
  output logic                        amo_req_o,
  input  logic                        amo_done_i,
  input  logic [rv_isa_pkg::XLEN-1:0] amo_result_i
);

  exu_pipe_pkg::ex_res_t   res_d;
  exu_pipe_pkg::redirect_t redirect_d;
  exu_pipe_pkg::bpu_upd_t  bpu_d;
  logic                    amo_misalign;

  exu u_exu (
    .req_i         (issue_i),
    .res_o         (res_d),
    .redirect_o    (redirect_d),
    .bpu_upd_o     (bpu_d),
    .amo_misalign_o(amo_misalign)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .res_d_i       (res_d),
    .redirect_d_i  (redirect_d),
    .bpu_d_i       (bpu_d),
    .amo_misalign_i(amo_misalign),
    .credit_i      (credit_i),
    .amo_done_i    (amo_done_i),
    .amo_result_i  (amo_result_i),
    .ex_stall_o    (ex_stall_o),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o),
    .redirect_o    (redirect_o),
    .bpu_upd_o     (bpu_upd_o),
    .amo_req_o     (amo_req_o)
  );

endmodule

//--- test/tb_exu_stage.sv
`timescale 1ns/100ps

module tb_exu_stage;

  typedef struct packed {
    rv_isa_pkg::exc_op_e exc;
    rv_isa_pkg::alu_op_e alu;
    rv_isa_pkg::csr_op_e csr;
    rv_isa_pkg::amo_op_e amo;
    logic [31:0] pc, rs1, rs2, imm, csr_data;
    logic [4:0]  csr_imm;
    logic        csr_imm_v, pdt;
    logic [31:0] exp_alu;
    logic        exp_rv;
    logic [31:0] exp_rpc;
    logic        exp_corr;
    logic [1:0]  exp_jt;
    logic [31:0] exp_csr;
    logic [7:0]  exp_trap;
    logic [31:0] amo_result;
  } vec_t;

  logic clk, rst, issue_valid, credit, amo_done;
  logic [rv_isa_pkg::XLEN-1:0] amo_result;
  exu_pipe_pkg::ex_req_t   issue;
  logic                    ex_stall, res_valid, amo_req;
  exu_pipe_pkg::ex_res_t   res;
  exu_pipe_pkg::redirect_t redirect;
  exu_pipe_pkg::bpu_upd_t  bpu_upd;

  vec_t vecs[$];
  exu_pipe_pkg::ex_res_t   exp_res_q[$];
  exu_pipe_pkg::redirect_t exp_rd_q[$];
  exu_pipe_pkg::bpu_upd_t  exp_bpu_q[$];
  int credit_due_q[$];
  int cycle, res_count, credit_count, last_due, idle_cycles;

  exu_stage UUT (
    .clk(clk), .rst(rst), .issue_valid_i(issue_valid), .issue_i(issue),
    .ex_stall_o(ex_stall), .res_valid_o(res_valid), .res_o(res),
    .redirect_o(redirect), .bpu_upd_o(bpu_upd), .credit_i(credit),
    .amo_req_o(amo_req), .amo_done_i(amo_done), .amo_result_i(amo_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_res(input exu_pipe_pkg::ex_res_t got, input exu_pipe_pkg::ex_res_t exp);
    if (got !== exp)
      stop_fail($sformatf("Error: res_o got %h expected %h (alu_data %h vs %h)",
                          got, exp, got.alu_data, exp.alu_data));
  endtask

  task automatic check_redirect(input exu_pipe_pkg::redirect_t got,
                                input exu_pipe_pkg::redirect_t exp);
    if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc))
      stop_fail($sformatf("Error: redirect_o got %h expected %h", got, exp));
  endtask

  task automatic check_bpu(input exu_pipe_pkg::bpu_upd_t got, input exu_pipe_pkg::bpu_upd_t exp);
    if (got.valid !== exp.valid || (exp.valid && got !== exp))
      stop_fail($sformatf("Error: bpu_upd_o got %h expected %h", got, exp));
  endtask

  // amo request fields travel on res_o while amo_req_o is high
  task automatic check_amo_req(input exu_pipe_pkg::ex_res_t got,
                               input rv_isa_pkg::amo_op_e exp_op,
                               input logic [rv_isa_pkg::XLEN-1:0] exp_rs2);
    if (got.amo_op !== exp_op || got.amo_rs2 !== exp_rs2)
      stop_fail($sformatf("Error: res_o.amo_op/amo_rs2 got %h/%h expected %h/%h",
                          got.amo_op, got.amo_rs2, exp_op, exp_rs2));
  endtask

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [31:0] f[20];
    vec_t v;
    fd = $fopen("test/exu_testdata.txt", "r");
    if (fd == 0) stop_fail("could not open the test data file");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 10 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                  f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
      if (n != 20) stop_fail("malformed line in the test data file");
      v.exc = rv_isa_pkg::exc_op_e'(f[0][3:0]);
      v.alu = rv_isa_pkg::alu_op_e'(f[1][3:0]);
      v.csr = rv_isa_pkg::csr_op_e'(f[2][1:0]);
      v.amo = rv_isa_pkg::amo_op_e'(f[3][3:0]);
      v.pc = f[4];
      v.rs1 = f[5];
      v.rs2 = f[6];
      v.imm = f[7];
      v.csr_data = f[8];
      v.csr_imm = f[9][4:0];
      v.csr_imm_v = f[10][0];
      v.pdt = f[11][0];
      v.exp_alu = f[12];
      v.exp_rv = f[13][0];
      v.exp_rpc = f[14];
      v.exp_corr = f[15][0];
      v.exp_jt = f[16][1:0];
      v.exp_csr = f[17];
      v.exp_trap = f[18][7:0];
      v.amo_result = f[19];
      vecs.push_back(v);
    end
    $fclose(fd);
  endtask

  // expected values follow the stage rules, data values come from the file
  task automatic push_expected(input vec_t v);
    exu_pipe_pkg::ex_res_t   r;
    exu_pipe_pkg::redirect_t d;
    exu_pipe_pkg::bpu_upd_t  b;
    logic is_amo;
    is_amo = (v.exc == rv_isa_pkg::EXC_AMO);
    r.pc = v.pc;
    r.rd = 5'd1;
    r.alu_data = v.exp_alu;
    r.csr_valid = (v.exc == rv_isa_pkg::EXC_CSR) && (v.csr != rv_isa_pkg::CSR_NONE);
    r.csr_addr = 12'h300;
    r.csr_data = v.exp_csr;
    r.amo_op = is_amo ? v.amo : rv_isa_pkg::AMO_NONE;
    r.amo_rs2 = v.rs2;
    r.trap = v.exp_trap;
    r.exc_op = v.exc;
    d.valid = v.exp_rv;
    d.pc = v.exp_rpc;
    b.valid = (v.exc == rv_isa_pkg::EXC_JAL) || (v.exc == rv_isa_pkg::EXC_JALR) ||
              (v.exc == rv_isa_pkg::EXC_BRANCH);
    b.taken = v.exp_corr ? v.pdt : ~v.pdt;
    b.correct = v.exp_corr;
    b.jump_type = v.exp_jt;
    b.pc = v.pc;
    b.pdt_which = ~v.pdt;
    b.history = 8'h5a;
    exp_res_q.push_back(r);
    exp_rd_q.push_back(d);
    exp_bpu_q.push_back(b);
  endtask

  task automatic drive_issue(input vec_t v);
    issue = '0;
    issue.pc = v.pc;
    issue.rd = 5'd1;
    issue.rs1 = v.rs1;
    issue.rs2 = v.rs2;
    issue.imm = v.imm;
    issue.csr_addr = 12'h300;
    issue.csr_data = v.csr_data;
    issue.csr_imm = v.csr_imm;
    issue.csr_imm_valid = v.csr_imm_v;
    issue.exc_op = v.exc;
    issue.alu_op = v.alu;
    issue.csr_op = v.csr;
    issue.amo_op = v.amo;
    issue.pdt_res = v.pdt;
    issue.pdt_which = ~v.pdt;  // varies so the passthrough is seen
    issue.history = 8'h5a;
    issue_valid = 1'b1;
  endtask

  // memory stage: results, credit returns and the stall check
  always @(negedge clk) begin
    int delay;
    if (!rst) begin
      cycle++;
      if (res_valid) begin
        if (exp_res_q.size() == 0) stop_fail("a result appeared with none expected");
        check_res(res, exp_res_q.pop_front());
        check_redirect(redirect, exp_rd_q.pop_front());
        check_bpu(bpu_upd, exp_bpu_q.pop_front());
        res_count++;
        delay = $urandom % 6;  // 0 to 5 cycles
        last_due = (cycle + delay > last_due + 1) ? cycle + delay : last_due + 1;
        credit_due_q.push_back(last_due);
        idle_cycles = 0;
      end else if (exp_res_q.size() != 0) begin
        idle_cycles++;
        if (idle_cycles > 200) stop_fail("timeout waiting for a result");
      end
      if (exu_pipe_pkg::EX_CREDITS - res_count + credit_count < 0)
        stop_fail("more results outstanding than credits");
      if (exu_pipe_pkg::EX_CREDITS - res_count + credit_count == 0 && !ex_stall)
        stop_fail("ex_stall_o low with no credit left");
      credit = 1'b0;
      if (credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
        void'(credit_due_q.pop_front());
        credit = 1'b1;
        credit_count++;
      end
    end
  end

  initial begin
    int t;
    vec_t v;
    void'($urandom(32'h370e_6d61));
    rst = 1'b1;
    issue_valid = 1'b0;
    issue = '0;
    credit = 1'b0;
    amo_done = 1'b0;
    amo_result = '0;
    cycle = 0;
    res_count = 0;
    credit_count = 0;
    last_due = 0;
    idle_cycles = 0;
    load_vectors();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    foreach (vecs[i]) begin
      v = vecs[i];
      drive_issue(v);
      t = 0;
      while (ex_stall) begin  // hold until the stage takes it
        @(negedge clk);
        t++;
        if (t > 200) stop_fail("timeout waiting for the stage to accept");
      end
      push_expected(v);
      @(negedge clk);
      issue_valid = 1'b0;
      if (v.exc == rv_isa_pkg::EXC_AMO && v.rs1[1:0] == 2'b00) begin
        t = 0;
        while (!amo_req) begin
          @(negedge clk);
          t++;
          if (t > 200) stop_fail("timeout waiting for amo_req_o");
        end
        check_amo_req(res, v.amo, v.rs2);
        repeat ($urandom % 6) @(negedge clk);
        amo_done = 1'b1;
        amo_result = v.amo_result;
        @(negedge clk);
        amo_done = 1'b0;
      end else if (amo_req) begin
        stop_fail("amo_req_o raised for an instruction that should not request");
      end
    end
    t = 0;
    while (exp_res_q.size() != 0) begin
      @(negedge clk);
      t++;
      if (t > 200) stop_fail("timeout waiting for the last results");
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- src.f
hw/rv_isa_pkg.sv
hw/exu_pipe_pkg.sv
hw/alu.sv
hw/branch_unit.sv
hw/exu.sv
hw/ex_mem_reg.sv
hw/exu_stage.sv
test/tb_exu_stage.sv

//--- run.sh
#!/bin/sh
# build and run from the project root, exit status carries the result
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module tb_exu_stage -f src.f -o sim_exu &&
  ./obj_dir/sim_exu ||
  { echo "simulation failed"; exit 1; }

//--- test/exu_testdata.txt
# exc alu csr amo pc rs1 rs2 imm csr_data csr_imm csr_imm_v pdt
# exp_alu exp_redirect_valid exp_redirect_pc exp_correct exp_jump_type exp_csr exp_trap amo_result
9 0 0 0 00000100 00000005 00000007 00000000 00000000 00 0 0 0000000c 0 00000000 0 0 00000000 00 00000000
9 1 0 0 00000104 00000005 00000007 00000000 00000000 00 0 0 fffffffe 0 00000000 0 0 00000000 00 00000000
9 7 0 0 00000108 80000000 00000004 00000000 00000000 00 0 0 f8000000 0 00000000 0 0 00000000 00 00000000
9 3 0 0 0000010c ffffffff 00000001 00000000 00000000 00 0 0 00000001 0 00000000 0 0 00000000 00 00000000
9 4 0 0 00000110 ffffffff 00000001 00000000 00000000 00 0 0 00000000 0 00000000 0 0 00000000 00 00000000
8 5 0 0 00000114 0f0f0f0f 00000000 ffffffff 00000000 00 0 0 f0f0f0f0 0 00000000 0 0 00000000 00 00000000
8 2 0 0 00000118 00000001 00000000 0000001f 00000000 00 0 0 80000000 0 00000000 0 0 00000000 00 00000000
1 0 0 0 0000011c 00000000 00000000 12345678 00000000 00 0 0 12345000 0 00000000 0 0 00000000 00 00000000
2 0 0 0 00001000 00000000 00000000 00002abc 00000000 00 0 0 00003000 0 00000000 0 0 00000000 00 00000000
3 0 0 0 00002000 00000000 00000000 00000100 00000000 00 0 0 00002004 1 00002100 0 1 00000000 00 00000000
4 0 0 0 00003000 00004000 00000000 00000010 00000000 00 0 1 00003004 0 00000000 1 2 00000000 00 00000000
4 0 0 0 00003000 00004000 00000000 00000010 00000000 00 0 0 00003004 1 00004010 0 2 00000000 00 00000000
5 a 0 0 00005000 00000003 00000003 00000040 00000000 00 0 0 00000000 1 00005040 0 3 00000000 00 00000000
5 b 0 0 00005000 00000003 00000003 00000040 00000000 00 0 1 00000000 1 00005004 0 3 00000000 00 00000000
5 c 0 0 00005000 ffffffff 00000001 00000040 00000000 00 0 1 00000000 0 00000000 1 3 00000000 00 00000000
5 e 0 0 00005000 ffffffff 00000001 00000040 00000000 00 0 0 00000000 0 00000000 1 3 00000000 00 00000000
5 d 0 0 00005000 ffffffff 00000001 00000040 00000000 00 0 1 00000000 1 00005004 0 3 00000000 00 00000000
5 f 0 0 00005000 ffffffff 00000001 00000040 00000000 00 0 0 00000000 1 00005040 0 3 00000000 00 00000000
a 0 1 0 00006000 0000aaaa 00000000 00000000 00001234 00 0 0 00001234 0 00000000 0 0 0000aaaa 00 00000000
a 0 2 0 00006004 000000f0 00000000 00000000 0000000f 00 0 0 0000000f 0 00000000 0 0 000000ff 00 00000000
a 0 3 0 00006008 0000000f 00000000 00000000 000000ff 00 0 0 000000ff 0 00000000 0 0 000000f0 00 00000000
a 0 1 0 0000600c 0000ffff 00000000 00000000 00000000 1f 1 0 00000000 0 00000000 0 0 0000001f 00 00000000
a 0 2 0 00006010 0000ffff 00000000 00000000 00000001 10 1 0 00000001 0 00000000 0 0 00000011 00 00000000
a 0 3 0 00006014 0000ffff 00000000 00000000 000000ff 01 1 0 000000ff 0 00000000 0 0 000000fe 00 00000000
b 0 0 3 00007000 00008000 dead0001 00000000 00000000 00 0 0 cafef00d 0 00000000 0 0 00000000 00 cafef00d
b 0 0 4 00007004 00008002 00000001 00000000 00000000 00 0 0 00008003 0 00000000 0 0 00000000 40 00000000
b 0 0 4 00007008 00009000 00000005 00000000 00000000 00 0 0 12345678 0 00000000 0 0 00000000 00 12345678
9 8 0 0 0000700c 000000f0 0000000f 00000000 00000000 00 0 0 000000ff 0 00000000 0 0 00000000 00 00000000
